/* armPkg.sv */
`default_nettype none

package armPkg;

	localparam int dataWidth    = 32;
	localparam int regAddrWidth = 4;

	// Bit positions inside the NZCV flags word
	localparam int flagN = 3;
	localparam int flagZ = 2;
	localparam int flagC = 1;
	localparam int flagV = 0;

	typedef enum logic [3:0] {
		aluAdd = 4'h0,
		aluSub = 4'h1,
		aluAnd = 4'h2,
		aluOrr = 4'h3,
		aluEor = 4'h4,
		aluMov = 4'h5,
		aluMvn = 4'h6,
		aluMul = 4'h7,
		aluMla = 4'h8
	} aluOpT;

	// ARM condition field encodings, 4'hF is left unused
	typedef enum logic [3:0] {
		condEq = 4'h0,
		condNe = 4'h1,
		condCs = 4'h2,
		condCc = 4'h3,
		condMi = 4'h4,
		condPl = 4'h5,
		condVs = 4'h6,
		condVc = 4'h7,
		condHi = 4'h8,
		condLs = 4'h9,
		condGe = 4'hA,
		condLt = 4'hB,
		condGt = 4'hC,
		condLe = 4'hD,
		condAl = 4'hE
	} condT;

	// Operand source for the forwarding muxes
	typedef enum logic [1:0] {
		fwdReg = 2'd0,
		fwdWb  = 2'd1,
		fwdMem = 2'd2
	} fwdT;

endpackage

`default_nettype wire

/* alu.sv */
`default_nettype none

module alu import armPkg::*; (
	input  logic [dataWidth-1:0] a,
	input  logic [dataWidth-1:0] b,
	input  logic [dataWidth-1:0] c,
	input  aluOpT                aluControl,
	output logic [dataWidth-1:0] result,
	output logic [3:0]           flags
);

	logic [dataWidth:0]   sum;
	logic [dataWidth-1:0] product;
	logic                 carry;
	logic                 overflow;

	// Only the low word of the product is kept
	assign product = a * b;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Adder with carry and overflow
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		sum      = '0;
		carry    = 1'b0;
		overflow = 1'b0;
		case (aluControl)
			aluAdd: begin
				sum      = {1'b0, a} + {1'b0, b};
				carry    = sum[dataWidth];
				overflow = (a[dataWidth-1] == b[dataWidth-1]) &&
					(sum[dataWidth-1] != a[dataWidth-1]);
			end
			aluSub: begin
				// Carry set here means no borrow, as on ARM
				sum      = {1'b0, a} + {1'b0, ~b} + (dataWidth + 1)'(1);
				carry    = sum[dataWidth];
				overflow = (a[dataWidth-1] != b[dataWidth-1]) &&
					(sum[dataWidth-1] != a[dataWidth-1]);
			end
			default: begin
			end
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Result select
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		case (aluControl)
			aluAdd:  result = sum[dataWidth-1:0];
			aluSub:  result = sum[dataWidth-1:0];
			aluAnd:  result = a & b;
			aluOrr:  result = a | b;
			aluEor:  result = a ^ b;
			aluMov:  result = b;
			aluMvn:  result = ~b;
			aluMul:  result = product;
			aluMla:  result = product + c;
			default: result = '0;
		endcase
	end

	// N and Z follow the result for every operation
	assign flags[flagN] = result[dataWidth-1];
	assign flags[flagZ] = (result == '0);
	assign flags[flagC] = carry;
	assign flags[flagV] = overflow;

	// Decode upstream must never hand over a code outside the table
	always_comb begin
		assert final (aluControl inside {aluAdd, aluSub, aluAnd, aluOrr, aluEor,
			aluMov, aluMvn, aluMul, aluMla})
		else $error("alu: unlisted operation code %0h", aluControl);
	end

endmodule

`default_nettype wire

/* condUnit.sv */
`default_nettype none

module condUnit import armPkg::*; (
	input  logic       Clk,
	input  logic       rstN,
	input  logic [3:0] aluFlags,
	input  condT       cond,
	input  logic       flagWrite,
	output logic       condEx,
	output logic [3:0] flags
);

	logic n;
	logic z;
	logic cf;
	logic v;

	assign n  = flags[flagN];
	assign z  = flags[flagZ];
	assign cf = flags[flagC];
	assign v  = flags[flagV];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Condition check against the stored flags
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		case (cond)
			condEq:  condEx = z;
			condNe:  condEx = !z;
			condCs:  condEx = cf;
			condCc:  condEx = !cf;
			condMi:  condEx = n;
			condPl:  condEx = !n;
			condVs:  condEx = v;
			condVc:  condEx = !v;
			condHi:  condEx = cf && !z;
			condLs:  condEx = !cf || z;
			condGe:  condEx = (n == v);
			condLt:  condEx = (n != v);
			condGt:  condEx = !z && (n == v);
			condLe:  condEx = z || (n != v);
			condAl:  condEx = 1'b1;
			// The spare code never executes
			default: condEx = 1'b0;
		endcase
	end

	// A failed condition leaves the flags untouched even with flagWrite set
	always_ff @(posedge Clk) begin
		if (!rstN) begin
			flags <= 4'b0000;
		end else if (flagWrite && condEx) begin
			flags <= aluFlags;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	alwaysExecutes: assert property (@(posedge Clk) disable iff (!rstN)
		(cond == condAl) |-> condEx)
	else $error("condUnit: condAl did not execute");

endmodule

`default_nettype wire

/* forwardUnit.sv */
`default_nettype none

module forwardUnit import armPkg::*; (
	input  logic [regAddrWidth-1:0] ra1E,
	input  logic [regAddrWidth-1:0] ra2E,
	input  logic [regAddrWidth-1:0] wa3M,
	input  logic [regAddrWidth-1:0] wa3W,
	input  logic                    regWriteM,
	input  logic                    regWriteW,
	output fwdT                     forwardA,
	output fwdT                     forwardB
);

	// Memory stage holds the younger value, so it wins over writeback
	function automatic fwdT pickSource(input logic [regAddrWidth-1:0] ra);
		fwdT sel;
		if (regWriteM && (ra == wa3M)) begin
			sel = fwdMem;
		end else if (regWriteW && (ra == wa3W)) begin
			sel = fwdWb;
		end else begin
			sel = fwdReg;
		end
		return sel;
	endfunction

	always_comb begin
		forwardA = pickSource(ra1E);
		forwardB = pickSource(ra2E);
	end

	always_comb begin
		assert final ((2'(forwardA) != 2'd3) && (2'(forwardB) != 2'd3))
		else $error("forwardUnit: select took the unused value 3");
	end

endmodule

`default_nettype wire

/* pipeExeMem.sv */
`default_nettype none

module pipeExeMem import armPkg::*; (
	input  logic                    Clk,
	input  logic                    rstN,
	input  logic [dataWidth-1:0]    aluResultE,
	input  logic [dataWidth-1:0]    writeDataE,
	input  logic [regAddrWidth-1:0] wa3E,
	input  logic                    pcSrcE,
	input  logic                    regWriteE,
	input  logic                    memToRegE,
	input  logic                    memWriteE,
	output logic [dataWidth-1:0]    aluResultM,
	output logic [dataWidth-1:0]    writeDataM,
	output logic [regAddrWidth-1:0] wa3M,
	output logic                    pcSrcM,
	output logic                    regWriteM,
	output logic                    memToRegM,
	output logic                    memWriteM
);

	// The controls arrive already gated by the condition check
	always_ff @(posedge Clk) begin
		if (!rstN) begin
			aluResultM <= '0;
			writeDataM <= '0;
			wa3M       <= '0;
			pcSrcM     <= 1'b0;
			regWriteM  <= 1'b0;
			memToRegM  <= 1'b0;
			memWriteM  <= 1'b0;
		end else begin
			aluResultM <= aluResultE;
			writeDataM <= writeDataE;
			wa3M       <= wa3E;
			pcSrcM     <= pcSrcE;
			regWriteM  <= regWriteE;
			memToRegM  <= memToRegE;
			memWriteM  <= memWriteE;
		end
	end

endmodule

`default_nettype wire

/* executeStage.sv */
`default_nettype none

module executeStage import armPkg::*; (
	input  logic                    Clk,
	input  logic                    rstN,
	input  logic [dataWidth-1:0]    dataRegA,
	input  logic [dataWidth-1:0]    dataRegB,
	input  logic [dataWidth-1:0]    dataRegC,
	input  logic [dataWidth-1:0]    ext,
	input  logic [dataWidth-1:0]    resultW,
	input  logic [regAddrWidth-1:0] wa3E,
	input  aluOpT                   aluControlE,
	input  condT                    condE,
	input  fwdT                     forwardA,
	input  fwdT                     forwardB,
	input  logic                    aluSrcE,
	input  logic                    regWriteE,
	input  logic                    pcSrcE,
	input  logic                    branchE,
	input  logic                    memToRegE,
	input  logic                    memWriteE,
	input  logic                    flagWriteE,
	output logic [dataWidth-1:0]    aluResultE,
	output logic [3:0]              flagsE,
	output logic                    branchTakenE,
	output logic [dataWidth-1:0]    aluResultM,
	output logic [dataWidth-1:0]    writeDataM,
	output logic [regAddrWidth-1:0] wa3M,
	output logic                    pcSrcM,
	output logic                    regWriteM,
	output logic                    memToRegM,
	output logic                    memWriteM
);

	logic [dataWidth-1:0] srcA;
	logic [dataWidth-1:0] fwdB;
	logic [dataWidth-1:0] srcB;
	logic [3:0]           aluFlags;
	logic                 condEx;
	logic                 regWriteG;
	logic                 pcSrcG;
	logic                 memWriteG;

	// The memory-stage source is the registered ALU result of this stage
	function automatic logic [dataWidth-1:0] fwdMux(input fwdT sel,
		input logic [dataWidth-1:0] regVal);
		logic [dataWidth-1:0] y;
		case (sel)
			fwdWb:   y = resultW;
			fwdMem:  y = aluResultM;
			default: y = regVal;
		endcase
		return y;
	endfunction

	assign srcA = fwdMux(forwardA, dataRegA);
	assign fwdB = fwdMux(forwardB, dataRegB);
	assign srcB = aluSrcE ? ext : fwdB;

	alu alu_i (.a(srcA), .b(srcB), .c(dataRegC), .aluControl(aluControlE),
		.result(aluResultE), .flags(aluFlags));

	condUnit condUnit_i (.Clk(Clk), .rstN(rstN), .aluFlags(aluFlags), .cond(condE),
		.flagWrite(flagWriteE), .condEx(condEx), .flags(flagsE));

	// Stores are gated as well so a failed store never reaches memory
	assign regWriteG    = regWriteE && condEx;
	assign pcSrcG       = pcSrcE && condEx;
	assign memWriteG    = memWriteE && condEx;
	assign branchTakenE = branchE && condEx;

	pipeExeMem pipeEM_i (.Clk(Clk), .rstN(rstN), .aluResultE(aluResultE),
		.writeDataE(fwdB), .wa3E(wa3E), .pcSrcE(pcSrcG), .regWriteE(regWriteG),
		.memToRegE(memToRegE), .memWriteE(memWriteG), .aluResultM(aluResultM),
		.writeDataM(writeDataM), .wa3M(wa3M), .pcSrcM(pcSrcM), .regWriteM(regWriteM),
		.memToRegM(memToRegM), .memWriteM(memWriteM));

	noSideEffects: assert property (@(posedge Clk) disable iff (!rstN)
		!condEx |=> !(regWriteM || pcSrcM || memWriteM))
	else $error("executeStage: a failed instruction reached the memory stage");

endmodule

`default_nettype wire

/* executeTop.sv */
`default_nettype none

module executeTop import armPkg::*; (
	input  logic                    Clk,
	input  logic                    rstN,
	input  logic [dataWidth-1:0]    dataRegA,
	input  logic [dataWidth-1:0]    dataRegB,
	input  logic [dataWidth-1:0]    dataRegC,
	input  logic [dataWidth-1:0]    ext,
	input  logic [regAddrWidth-1:0] ra1E,
	input  logic [regAddrWidth-1:0] ra2E,
	input  logic [regAddrWidth-1:0] wa3E,
	input  aluOpT                   aluControlE,
	input  condT                    condE,
	input  logic                    regWriteE,
	input  logic                    pcSrcE,
	input  logic                    branchE,
	input  logic                    aluSrcE,
	input  logic                    memToRegE,
	input  logic                    memWriteE,
	input  logic                    flagWriteE,
	input  logic [dataWidth-1:0]    resultW,
	input  logic [regAddrWidth-1:0] wa3W,
	input  logic                    regWriteW,
	output logic [dataWidth-1:0]    aluResultE,
	output logic [3:0]              flagsE,
	output logic                    branchTakenE,
	output logic [dataWidth-1:0]    aluResultM,
	output logic [dataWidth-1:0]    writeDataM,
	output logic [regAddrWidth-1:0] wa3M,
	output logic                    pcSrcM,
	output logic                    regWriteM,
	output logic                    memToRegM,
	output logic                    memWriteM
);

	fwdT forwardA;
	fwdT forwardB;

	// The memory-stage destination loops back from the pipeline register
	forwardUnit forwardUnit_i (.ra1E(ra1E), .ra2E(ra2E), .wa3M(wa3M), .wa3W(wa3W),
		.regWriteM(regWriteM), .regWriteW(regWriteW), .forwardA(forwardA),
		.forwardB(forwardB));

	executeStage executeStage_i (.Clk(Clk), .rstN(rstN), .dataRegA(dataRegA),
		.dataRegB(dataRegB), .dataRegC(dataRegC), .ext(ext), .resultW(resultW),
		.wa3E(wa3E), .aluControlE(aluControlE), .condE(condE), .forwardA(forwardA),
		.forwardB(forwardB), .aluSrcE(aluSrcE), .regWriteE(regWriteE),
		.pcSrcE(pcSrcE), .branchE(branchE), .memToRegE(memToRegE),
		.memWriteE(memWriteE), .flagWriteE(flagWriteE), .aluResultE(aluResultE),
		.flagsE(flagsE), .branchTakenE(branchTakenE), .aluResultM(aluResultM),
		.writeDataM(writeDataM), .wa3M(wa3M), .pcSrcM(pcSrcM),
		.regWriteM(regWriteM), .memToRegM(memToRegM), .memWriteM(memWriteM));

endmodule

`default_nettype wire

/* tbExecute.sv */
`default_nettype none

module tbExecute import armPkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int minCycles = 3000;
	localparam int maxCycles = 40000;

	logic                    Clk = 1'b0;
	logic                    rstN;
	logic [dataWidth-1:0]    dataRegA;
	logic [dataWidth-1:0]    dataRegB;
	logic [dataWidth-1:0]    dataRegC;
	logic [dataWidth-1:0]    ext;
	logic [regAddrWidth-1:0] ra1E;
	logic [regAddrWidth-1:0] ra2E;
	logic [regAddrWidth-1:0] wa3E;
	aluOpT                   aluControlE;
	condT                    condE;
	logic                    regWriteE;
	logic                    pcSrcE;
	logic                    branchE;
	logic                    aluSrcE;
	logic                    memToRegE;
	logic                    memWriteE;
	logic                    flagWriteE;
	logic [dataWidth-1:0]    resultW;
	logic [regAddrWidth-1:0] wa3W;
	logic                    regWriteW;
	logic [dataWidth-1:0]    aluResultE;
	logic [3:0]              flagsE;
	logic                    branchTakenE;
	logic [dataWidth-1:0]    aluResultM;
	logic [dataWidth-1:0]    writeDataM;
	logic [regAddrWidth-1:0] wa3M;
	logic                    pcSrcM;
	logic                    regWriteM;
	logic                    memToRegM;
	logic                    memWriteM;

	logic [31:0]             lfsrState = 32'd94;
	int                      errorCount = 0;
	int                      timeoutCount = 0;
	int                      cycleCount = 0;
	logic                    idleWindow = 1'b0;
	logic                    running = 1'b0;

	// Shadow of the flag register and the memory-stage register
	logic [3:0]              shadowFlags;
	logic [dataWidth-1:0]    shadowAluM;
	logic [dataWidth-1:0]    shadowWriteData;
	logic [regAddrWidth-1:0] shadowWa3M;
	logic                    shadowRegWriteM;
	logic                    shadowPcSrcM;
	logic                    shadowMemWriteM;
	logic                    shadowMemToRegM;

	logic [1:0]              selA;
	logic [1:0]              selB;
	logic [dataWidth-1:0]    opA;
	logic [dataWidth-1:0]    opB;
	logic [dataWidth-1:0]    aluB;
	logic [dataWidth-1:0]    expResult;
	logic [3:0]              expFlags;
	logic                    expPass;

	bit                      condPass [0:14];
	bit                      condFail [0:14];
	bit                      opSeen [0:8];
	bit                      fwdMemSeen = 1'b0;
	bit                      fwdWbSeen = 1'b0;
	bit                      fwdBothSeen = 1'b0;

	executeTop executeTop_i (.*);

	always #4 Clk = ~Clk;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference models
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [31:0] aluModel(input aluOpT op, input logic [31:0] a,
		input logic [31:0] b, input logic [31:0] c);
		case (op)
			aluAdd:  return a + b;
			aluSub:  return a - b;
			aluAnd:  return a & b;
			aluOrr:  return a | b;
			aluEor:  return a ^ b;
			aluMov:  return b;
			aluMvn:  return ~b;
			aluMul:  return a * b;
			aluMla:  return a * b + c;
			default: return 32'h0;
		endcase
	endfunction

	function automatic logic [3:0] flagsModel(input aluOpT op, input logic [31:0] a,
		input logic [31:0] b, input logic [31:0] r);
		logic [3:0]  f;
		logic [32:0] wide;
		f = 4'b0000;
		f[flagN] = r[31];
		f[flagZ] = (r == 32'h0);
		if (op == aluAdd) begin
			wide = {1'b0, a} + {1'b0, b};
			f[flagC] = wide[32];
			f[flagV] = (a[31] == b[31]) && (r[31] != a[31]);
		end else if (op == aluSub) begin
			// No borrow when a is at least b
			f[flagC] = (a >= b);
			f[flagV] = (a[31] != b[31]) && (r[31] != a[31]);
		end
		return f;
	endfunction

	function automatic logic condModel(input condT cond, input logic [3:0] f);
		case (cond)
			condEq:  return f[flagZ];
			condNe:  return !f[flagZ];
			condCs:  return f[flagC];
			condCc:  return !f[flagC];
			condMi:  return f[flagN];
			condPl:  return !f[flagN];
			condVs:  return f[flagV];
			condVc:  return !f[flagV];
			condHi:  return f[flagC] && !f[flagZ];
			condLs:  return !f[flagC] || f[flagZ];
			condGe:  return f[flagN] == f[flagV];
			condLt:  return f[flagN] != f[flagV];
			condGt:  return !f[flagZ] && (f[flagN] == f[flagV]);
			condLe:  return f[flagZ] || (f[flagN] != f[flagV]);
			condAl:  return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// 2 is the memory stage, 1 is writeback, 0 is the register file
	function automatic logic [1:0] sourceOf(input logic [3:0] ra, input logic [3:0] wM,
		input logic weM, input logic [3:0] wW, input logic weW);
		if (weM && (ra == wM))
			return 2'd2;
		if (weW && (ra == wW))
			return 2'd1;
		return 2'd0;
	endfunction

	function automatic logic [31:0] operandFor(input logic [1:0] sel,
		input logic [31:0] regVal, input logic [31:0] memVal, input logic [31:0] wbVal);
		return (sel == 2'd2) ? memVal : ((sel == 2'd1) ? wbVal : regVal);
	endfunction

	always_comb begin
		selA      = sourceOf(ra1E, shadowWa3M, shadowRegWriteM, wa3W, regWriteW);
		selB      = sourceOf(ra2E, shadowWa3M, shadowRegWriteM, wa3W, regWriteW);
		opA       = operandFor(selA, dataRegA, shadowAluM, resultW);
		opB       = operandFor(selB, dataRegB, shadowAluM, resultW);
		aluB      = aluSrcE ? ext : opB;
		expResult = aluModel(aluControlE, opA, aluB, dataRegC);
		expFlags  = flagsModel(aluControlE, opA, aluB, expResult);
		expPass   = condModel(condE, shadowFlags);
	end

	always_ff @(posedge Clk) begin
		if (!rstN) begin
			shadowFlags     <= 4'b0000;
			shadowAluM      <= '0;
			shadowWriteData <= '0;
			shadowWa3M      <= '0;
			shadowRegWriteM <= 1'b0;
			shadowPcSrcM    <= 1'b0;
			shadowMemWriteM <= 1'b0;
			shadowMemToRegM <= 1'b0;
		end else begin
			if (flagWriteE && expPass)
				shadowFlags <= expFlags;
			shadowAluM      <= expResult;
			shadowWriteData <= opB;
			shadowWa3M      <= wa3E;
			shadowRegWriteM <= regWriteE && expPass;
			shadowPcSrcM    <= pcSrcE && expPass;
			shadowMemWriteM <= memWriteE && expPass;
			shadowMemToRegM <= memToRegE;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	aluResultOk: assert property (@(posedge Clk) disable iff (!rstN) aluResultE == expResult)
	else begin
		errorCount = errorCount + 1;
		$display("Mismatch at %0t: aluResultE is %h, expected %h", $time, aluResultE, expResult);
	end

	branchOk: assert property (@(posedge Clk) disable iff (!rstN)
		branchTakenE == (branchE && expPass))
	else begin
		errorCount = errorCount + 1;
		$display("Mismatch at %0t: branchTakenE is %b for cond %0d", $time, branchTakenE, condE);
	end

	flagsOk: assert property (@(posedge Clk) disable iff (!rstN) flagsE == shadowFlags)
	else begin
		errorCount = errorCount + 1;
		$display("Mismatch at %0t: flagsE is %b, expected %b", $time, flagsE, shadowFlags);
	end

	memDataOk: assert property (@(posedge Clk) disable iff (!rstN)
		(aluResultM == shadowAluM) && (writeDataM == shadowWriteData) && (wa3M == shadowWa3M))
	else begin
		errorCount = errorCount + 1;
		$display("Mismatch at %0t: memory data %h %h %h, expected %h %h %h", $time,
			aluResultM, writeDataM, wa3M, shadowAluM, shadowWriteData, shadowWa3M);
	end

	memCtrlOk: assert property (@(posedge Clk) disable iff (!rstN)
		{regWriteM, pcSrcM, memWriteM, memToRegM} ==
		{shadowRegWriteM, shadowPcSrcM, shadowMemWriteM, shadowMemToRegM})
	else begin
		errorCount = errorCount + 1;
		$display("Mismatch at %0t: memory controls %b, expected %b", $time,
			{regWriteM, pcSrcM, memWriteM, memToRegM},
			{shadowRegWriteM, shadowPcSrcM, shadowMemWriteM, shadowMemToRegM});
	end

	resetStateOk: assert property (@(posedge Clk) !idleWindow ||
		(({pcSrcM, regWriteM, memToRegM, memWriteM} == 4'b0000) && (flagsE == 4'b0000)))
	else begin
		errorCount = errorCount + 1;
		$display("Mismatch at %0t: state after reset is not clear, flags %b", $time, flagsE);
	end

	always @(posedge Clk) begin
		if (running) begin
			opSeen[aluControlE] <= 1'b1;
			if (expPass)
				condPass[condE] <= 1'b1;
			else
				condFail[condE] <= 1'b1;
			if (selA == 2'd2 || selB == 2'd2)
				fwdMemSeen <= 1'b1;
			if (selA == 2'd1 || selB == 2'd1)
				fwdWbSeen <= 1'b1;
			if (shadowRegWriteM && regWriteW && (wa3W == shadowWa3M) && (selA == 2'd2))
				fwdBothSeen <= 1'b1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Galois form of x^32 + x^22 + x^2 + x + 1, one step per bit
	function automatic logic [31:0] takeBits(input int n);
		logic [31:0] v;
		v = 32'h0;
		for (int k = 0; k < n; k++) begin
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
			v = {v[30:0], lfsrState[0]};
		end
		return v;
	endfunction

	// Small values make zero results and equal operands likely
	function automatic logic [31:0] randomOperand();
		logic [31:0] v;
		if (takeBits(1) != 0) begin
			v = takeBits(32);
		end else begin
			v = takeBits(4);
		end
		return v;
	endfunction

	function automatic logic [3:0] randomSource();
		logic [1:0] kind;
		kind = 2'(takeBits(2));
		if (kind == 2'd0)
			return shadowWa3M;
		if (kind == 2'd1)
			return wa3W;
		return 4'(takeBits(4));
	endfunction

	function automatic bit coverageDone();
		bit done;
		done = fwdMemSeen && fwdWbSeen && fwdBothSeen;
		for (int k = 0; k < 15; k++) begin
			done = done && condPass[k];
			if (k != int'(condAl))
				done = done && condFail[k];
		end
		for (int k = 0; k < 9; k++)
			done = done && opSeen[k];
		return done;
	endfunction

	task automatic clearInputs();
		{dataRegA, dataRegB, dataRegC, ext, resultW} = '0;
		{ra1E, ra2E, wa3E, wa3W} = '0;
		aluControlE = aluAdd;
		condE       = condEq;
		{regWriteE, pcSrcE, branchE, aluSrcE, memToRegE, memWriteE} = 6'b0;
		flagWriteE  = 1'b0;
		regWriteW   = 1'b0;
	endtask

	task automatic driveRandom();
		logic [3:0] code;
		aluControlE = aluOpT'(4'(takeBits(4) % 9));
		code        = 4'(takeBits(4));
		condE       = (code == 4'hF) ? condAl : condT'(code);
		dataRegA    = randomOperand();
		dataRegB    = randomOperand();
		dataRegC    = randomOperand();
		ext         = randomOperand();
		wa3W        = 4'(takeBits(4));
		regWriteW   = 1'(takeBits(1));
		resultW     = randomOperand();
		ra1E        = randomSource();
		ra2E        = randomSource();
		wa3E        = 4'(takeBits(4));
		aluSrcE     = 1'(takeBits(1));
		regWriteE   = 1'(takeBits(1));
		pcSrcE      = 1'(takeBits(1));
		branchE     = 1'(takeBits(1));
		memToRegE   = 1'(takeBits(1));
		memWriteE   = 1'(takeBits(1));
		// Rare flag writes keep the flags long enough to test every condition
		flagWriteE  = (takeBits(2) == 0);
	endtask

	initial begin
		int n;
		clearInputs();
		rstN = 1'b0;
		for (n = 0; n < 8; n++)
			@(negedge Clk);
		rstN = 1'b1;
		idleWindow = 1'b1;
		n = 0;
		while ((regWriteM || pcSrcM || memWriteM || memToRegM || flagsE != 0) && n < 4) begin
			@(negedge Clk);
			n++;
		end
		if (regWriteM || pcSrcM || memWriteM || memToRegM || flagsE != 0) begin
			$display("Timeout: memory-stage controls and flags never cleared after reset");
			timeoutCount++;
		end
		@(negedge Clk);
		idleWindow = 1'b0;
		running = 1'b1;
		while ((cycleCount < minCycles || !coverageDone()) && cycleCount < maxCycles) begin
			driveRandom();
			@(negedge Clk);
			cycleCount++;
		end
		running = 1'b0;
		if (!coverageDone()) begin
			$display("Timeout: not every condition, operation and forwarding case was reached");
			timeoutCount++;
		end
		clearInputs();
		for (n = 0; n < 3; n++)
			@(negedge Clk);
		$display("Ran %0d cycles with %0d mismatches and %0d timeouts", cycleCount,
			errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
armPkg.sv
alu.sv
condUnit.sv
forwardUnit.sv
pipeExeMem.sv
executeStage.sv
executeTop.sv
tbExecute.sv

/* runSim.sh */
#!/bin/sh
# Builds the execute stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tbExecute \
	-f filelist.f -o simExecute > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/simExecute > sim.log 2>&1
cat sim.log

grep -q '\*\*\* TEST FAILED \*\*\*' sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q '\*\*\* TEST PASSED \*\*\*' sim.log \
	|| { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
exit 0
